// File: compile.f
design/fp_addsub_pkg.sv
design/fp_align.sv
design/fp_mant_add.sv
design/fp_normalize.sv
design/fp_pack.sv
design/fp_addsub_ctrl.sv
design/fp_addsub_top.sv
verif/fp_addsub_properties.sv
verif/fp_addsub_tb.sv

// File: run.sh
#!/bin/sh
# Build the FP add/sub simulation with Verilator, run it, look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module fp_addsub_tb \
    -f compile.f -o fp_addsub_sim \
    && ./obj_dir/fp_addsub_sim | tee /dev/stderr \
    | grep "Simulation completed successfully" > /dev/null \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

// File: verif/fp_addsub_tb.sv
// FP add/sub testbench
// Directed and random requests checked against an exact reference model

`timescale 1ns/1ps
`default_nettype none

module fp_addsub_tb;

    import fp_addsub_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 5;
    // Longest operation is about 35 cycles
    localparam int DONE_LIMIT    = 60;
    localparam int IDLE_WINDOW   = 50;
    localparam int MAX_OPS       = 40;
    localparam int OP_CYCLES     = 40;
    localparam int WATCHDOG_NS   = MAX_OPS * OP_CYCLES * CLK_PERIOD_NS + 2000;
    localparam int RANDOM_PAIRS  = 20;

    logic    clk_sys;
    logic    rst_sys_n;
    logic    start;
    fp_req_t req;
    logic    busy;
    logic    done;
    fp_rsp_t rsp;

    integer  seed;
    int      error_count;
    int      check_count;
    int      done_count;

    fp_addsub_top dut0 (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .start     (start),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp)
    );

    always #(CLK_PERIOD_NS / 2) clk_sys = ~clk_sys;

    // Done pulses seen, sampled mid-cycle
    always @(negedge clk_sys) begin
        if (!rst_sys_n) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
        end
    end

    // --------------------------------------
    // Reference model
    // --------------------------------------
    // Exact integer value, hidden one of the larger exponent at bit 47
    function automatic logic signed [63:0] operand_value(input logic [31:0] x, input int emax);
        logic [63:0] m;
        int          d;
        m = {40'd0, 1'b1, x[22:0]};
        d = emax - int'(x[30:23]);
        if (x[30:0] == 31'd0) begin
            return 64'sd0;
        end
        m = m << (24 - d);
        return x[31] ? -$signed(m) : $signed(m);
    endfunction

    function automatic fp_rsp_t model_addsub(input fp_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
        fp_rsp_t            r;
        logic signed [63:0] s;
        logic [63:0]        mag;
        logic [63:0]        mant;
        logic               neg;
        int                 emax;
        int                 p;
        int                 er;
        int                 i;
        r    = '0;
        emax = (a[30:23] > b[30:23]) ? int'(a[30:23]) : int'(b[30:23]);
        if (op == FP_OP_ADD) begin
            s = operand_value(a, emax) + operand_value(b, emax);
        end else begin
            s = operand_value(a, emax) - operand_value(b, emax);
        end
        neg = (s < 0);
        mag = neg ? -s : s;
        // Exact cancel is +0
        if (mag == 64'd0) begin
            r.zero = 1'b1;
            return r;
        end
        p = 0;
        for (i = 0; i < 64; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        er = emax + p - 47;
        // Keep 24 significant bits, rest dropped
        mant = (p >= 23) ? mag >> (p - 23) : mag << (23 - p);
        if (er > EXP_MAX) begin
            r.overflow = 1'b1;
            r.result   = {neg, 8'hff, 23'd0};
        end else begin
            r.result   = {neg, er[7:0], mant[22:0]};
        end
        return r;
    endfunction

    // --------------------------------------
    // Drive and check helpers
    // --------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic issue_request(input fp_op_e op, input logic [31:0] a, input logic [31:0] b);
        @(negedge clk_sys);
        req   = {op, a, b};
        start = 1'b1;
        @(negedge clk_sys);
        start = 1'b0;
    endtask

    task automatic wait_for_done(input string name);
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            @(negedge clk_sys);
            cycles++;
        end
        assert (done) else begin
            $display("%s: no done pulse within %0d cycles", name, DONE_LIMIT);
            error_count++;
        end
    endtask

    task automatic run_op(input string name, input fp_op_e op, input logic [31:0] a,
                          input logic [31:0] b);
        fp_rsp_t expected;
        expected = model_addsub(op, a, b);
        issue_request(op, a, b);
        wait_for_done(name);
        check_value(name, {30'd0, expected}, {30'd0, rsp});
    endtask

    // --------------------------------------
    // Directed tests
    // --------------------------------------
    task automatic check_reset_values();
        @(negedge clk_sys);
        check_value("reset_busy", 64'd0, {63'd0, busy});
        check_value("reset_done", 64'd0, {63'd0, done});
        check_value("reset_rsp", 64'd0, {30'd0, rsp});
    endtask

    // Same-sign sums that carry into a new exponent
    task automatic test_carry_add();
        run_op("carry_pos", FP_OP_ADD, 32'h3fc0_0000, 32'h3fe0_0000);
        run_op("carry_neg", FP_OP_ADD, 32'hc120_0000, 32'hc130_0000);
        run_op("carry_sub_mixed", FP_OP_SUB, 32'h4040_0000, 32'hc0a0_0000);
    endtask

    // Deep cancellation, long leading-one search
    task automatic test_cancel_sub();
        run_op("cancel_ulp", FP_OP_SUB, 32'h3f80_0001, 32'h3f80_0000);
        run_op("cancel_diff_exp", FP_OP_SUB, 32'h4000_0000, 32'h3fff_ffff);
        run_op("cancel_neg", FP_OP_ADD, 32'hc120_0001, 32'h4120_0000);
    endtask

    task automatic test_zero_operand();
        run_op("zero_plus_x", FP_OP_ADD, 32'h0000_0000, 32'h4049_0fdb);
        run_op("zero_minus_x", FP_OP_SUB, 32'h0000_0000, 32'h4049_0fdb);
        run_op("x_minus_zero", FP_OP_SUB, 32'h4049_0fdb, 32'h0000_0000);
        run_op("neg_zero_plus_x", FP_OP_ADD, 32'h8000_0000, 32'h3f80_0000);
        run_op("x_minus_x", FP_OP_SUB, 32'hc2f6_e979, 32'hc2f6_e979);
    endtask

    // Both operands at the top exponent
    task automatic test_overflow();
        run_op("overflow_pos", FP_OP_ADD, 32'h7f7f_ffff, 32'h7f7f_ffff);
        run_op("overflow_neg", FP_OP_ADD, 32'hff00_0000, 32'hff7f_ffff);
        run_op("overflow_sub", FP_OP_SUB, 32'h7f7f_ffff, 32'hff7f_ffff);
    endtask

    // Second start mid-operation must be dropped
    task automatic test_start_while_busy();
        fp_rsp_t expected;
        int      done_before;
        expected = model_addsub(FP_OP_ADD, 32'h3fc0_0000, 32'h4010_0000);
        issue_request(FP_OP_ADD, 32'h3fc0_0000, 32'h4010_0000);
        done_before = done_count;
        repeat (2) @(negedge clk_sys);
        check_value("busy_during_op", 64'd1, {63'd0, busy});
        req   = {FP_OP_SUB, 32'h42c8_0000, 32'h3f80_0000};
        start = 1'b1;
        @(negedge clk_sys);
        start = 1'b0;
        wait_for_done("start_while_busy");
        check_value("start_while_busy", {30'd0, expected}, {30'd0, rsp});
        repeat (IDLE_WINDOW) @(negedge clk_sys);
        assert (done_count - done_before == 1) else begin
            $display("start_while_busy: %0d done pulses seen, one expected",
                     done_count - done_before);
            error_count++;
        end
    endtask

    // Moderate exponents, difference of 24 or less
    task automatic test_random_pairs();
        logic [31:0] ra;
        logic [31:0] rb;
        int          ea;
        int          eb;
        int          d;
        fp_op_e      op;
        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            ea = 64 + int'({$random(seed)} % 128);
            d  = int'({$random(seed)} % 25);
            ra = $random(seed);
            rb = $random(seed);
            eb = ra[30] ? ea + d : ea - d;
            op = rb[30] ? FP_OP_ADD : FP_OP_SUB;
            run_op($sformatf("random_%0d", n), op, {ra[31], ea[7:0], ra[22:0]},
                   {rb[31], eb[7:0], rb[22:0]});
        end
    endtask

    // --------------------------------------
    // Main sequence and watchdog
    // --------------------------------------
    initial begin
        seed        = 32'h8455_2c03;
        error_count = 0;
        check_count = 0;
        clk_sys     = 1'b0;
        rst_sys_n   = 1'b0;
        start       = 1'b0;
        req         = '0;
        repeat (RESET_CYCLES) @(negedge clk_sys);
        rst_sys_n = 1'b1;
        check_reset_values();
        test_carry_add();
        test_cancel_sub();
        test_zero_operand();
        test_overflow();
        test_start_while_busy();
        test_random_pairs();
        $display("Errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fp_addsub_properties.sv
// FP add/sub handshake and flag checks
// Bound into the top level

`timescale 1ns/1ps
`default_nettype none

module fp_addsub_properties (
    input wire                          clk_sys,
    input wire                          rst_sys_n,
    input wire                          busy,
    input wire                          done,
    input wire fp_addsub_pkg::fp_rsp_t  rsp
);

    // Done is a single-cycle pulse
    done_one_cycle: assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n) done |=> !done
    ) else $error("done held high for more than one cycle");

    // Done only closes a busy period
    done_after_busy: assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n) $rose(done) |-> $past(busy)
    ) else $error("done rose without a preceding busy cycle");

    // Flags are exclusive
    flags_exclusive: assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n) !(rsp.zero && rsp.overflow)
    ) else $error("zero and overflow flags both set");

endmodule

bind fp_addsub_top fp_addsub_properties u_props (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_sys_n),
    .busy      (busy),
    .done      (done),
    .rsp       (rsp)
);

`default_nettype wire

// File: design/fp_addsub_top.sv
// FP add/sub top level
// Controller plus align, add, normalize and pack stages

`timescale 1ns/1ps
`default_nettype none

module fp_addsub_top (
    input  wire                       clk_sys,
    input  wire                       rst_sys_n,
    input  wire                       start,
    input  wire fp_addsub_pkg::fp_req_t req,
    output logic                      busy,
    output logic                      done,
    output fp_addsub_pkg::fp_rsp_t    rsp
);

    import fp_addsub_pkg::*;

    // Step broadcast and search feedback
    fp_step_e    step;
    logic        lead_found;

    // Stage to stage data
    fp_aligned_t aligned;
    fp_op_e      op;
    fp_sum_t     sum;
    fp_sum_t     norm;

    fp_addsub_ctrl u_ctrl (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .start      (start),
        .lead_found (lead_found),
        .step       (step),
        .busy       (busy),
        .done       (done)
    );

    fp_align u_align (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .step      (step),
        .req       (req),
        .aligned   (aligned),
        .op        (op)
    );

    fp_mant_add u_mant_add (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .step      (step),
        .aligned   (aligned),
        .op        (op),
        .sum       (sum)
    );

    fp_normalize u_normalize (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .step       (step),
        .sum        (sum),
        .norm       (norm),
        .lead_found (lead_found)
    );

    fp_pack u_pack (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .step      (step),
        .norm      (norm),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// File: design/fp_addsub_ctrl.sv
// FP add/sub step sequencer
// Walks the datapath steps, holds in search until the leading one shows up

`timescale 1ns/1ps
`default_nettype none

module fp_addsub_ctrl (
    input  wire                       clk_sys,
    input  wire                       rst_sys_n,
    input  wire                       start,
    input  wire                       lead_found,
    output fp_addsub_pkg::fp_step_e   step,
    output logic                      busy,
    output logic                      done
);

    import fp_addsub_pkg::*;

    fp_step_e step_nxt;

    // --------------------------------------
    // Next step
    // --------------------------------------
    always_comb begin
        step_nxt = step;
        case (step)
            ST_IDLE: begin
                // start only seen here, so a start while busy is dropped
                if (start) begin
                    step_nxt = ST_UNPACK;
                end
            end
            ST_UNPACK:    step_nxt = ST_EXPDIFF;
            ST_EXPDIFF:   step_nxt = ST_ALIGN;
            ST_ALIGN:     step_nxt = ST_SIGNED;
            ST_SIGNED:    step_nxt = ST_ADD;
            ST_ADD:       step_nxt = ST_MAGNITUDE;
            ST_MAGNITUDE: step_nxt = ST_SEARCH;
            ST_SEARCH: begin
                // One bit checked per cycle
                if (lead_found) begin
                    step_nxt = ST_SHIFT;
                end
            end
            ST_SHIFT:     step_nxt = ST_PACK;
            ST_PACK:      step_nxt = ST_IDLE;
            default:      step_nxt = ST_IDLE;
        endcase
    end

    // --------------------------------------
    // Step, busy and done registers
    // --------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            step <= ST_IDLE;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            step <= step_nxt;
            // Busy drops on the same edge that raises done
            busy <= (step_nxt != ST_IDLE);
            // Pulse in the cycle after pack
            done <= (step == ST_PACK);
        end
    end

endmodule

`default_nettype wire

// File: design/fp_pack.sv
// FP result packer
// Zero and overflow detection, truncated fraction, registered response

`timescale 1ns/1ps
`default_nettype none

module fp_pack (
    input  wire                         clk_sys,
    input  wire                         rst_sys_n,
    input  wire fp_addsub_pkg::fp_step_e step,
    input  wire fp_addsub_pkg::fp_sum_t  norm,
    output fp_addsub_pkg::fp_rsp_t      rsp
);

    import fp_addsub_pkg::*;

    // Leading one sits at the top after normalize
    logic [MANT_W-1:0] mant;

    assign mant = norm.magnitude[EXT_W-1 -: MANT_W];

    // Response held from one done to the next
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            rsp <= '0;
        end else if (step == ST_PACK) begin
            if (mant == '0) begin
                // Exact cancel or zero inputs give +0
                rsp.overflow <= 1'b0;
                rsp.zero     <= 1'b1;
                rsp.result   <= '0;
            end else if (norm.exponent > EXP_MAX) begin
                // Signed infinity
                rsp.overflow <= 1'b1;
                rsp.zero     <= 1'b0;
                rsp.result   <= {norm.sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
            end else begin
                // Guard bits dropped, no rounding
                rsp.overflow <= 1'b0;
                rsp.zero     <= 1'b0;
                rsp.result   <= {norm.sign, norm.exponent[EXP_W-1:0], mant[FRAC_W-1:0]};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fp_normalize.sv
// FP normalizer
// Bit-serial leading-one search from the carry bit, then a single shift

`timescale 1ns/1ps
`default_nettype none

module fp_normalize (
    input  wire                         clk_sys,
    input  wire                         rst_sys_n,
    input  wire fp_addsub_pkg::fp_step_e step,
    input  wire fp_addsub_pkg::fp_sum_t  sum,
    output fp_addsub_pkg::fp_sum_t      norm,
    output logic                        lead_found
);

    import fp_addsub_pkg::*;

    // Distance from the carry bit, 0 to NORM_MAX
    logic [4:0] cnt;
    logic [5:0] lead_idx;
    // Left shift that moves the leading one to the hidden-one slot
    logic [4:0] shl;

    assign lead_idx   = 6'(EXT_W) - {1'b0, cnt};
    assign shl        = cnt - 5'd1;
    // Stop on the first one, or give up at the last position
    assign lead_found = (cnt == 5'(NORM_MAX)) || sum.magnitude[lead_idx];

    // --------------------------------------
    // Search counter
    // --------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            cnt <= '0;
        end else if (step == ST_MAGNITUDE) begin
            // Restart at the carry bit for each operation
            cnt <= '0;
        end else if (step == ST_SEARCH && !lead_found) begin
            cnt <= cnt + 5'd1;
        end
    end

    // --------------------------------------
    // Shift and exponent fix-up
    // --------------------------------------
    always_ff @(posedge clk_sys) begin
        if (step == ST_SHIFT) begin
            norm.sign <= sum.sign;
            if (sum.magnitude[EXT_W]) begin
                // Carry out of the add
                norm.magnitude <= sum.magnitude >> 1;
                norm.exponent  <= sum.exponent + 10'd1;
            end else if (sum.magnitude[lead_idx]) begin
                norm.magnitude <= sum.magnitude << shl;
                norm.exponent  <= sum.exponent - {5'd0, shl};
            end else begin
                // Nothing found, result is zero
                norm.magnitude <= sum.magnitude;
                norm.exponent  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fp_mant_add.sv
// FP mantissa adder
// Two's complement add or subtract, then sign and magnitude split

`timescale 1ns/1ps
`default_nettype none

module fp_mant_add (
    input  wire                             clk_sys,
    input  wire                             rst_sys_n,
    input  wire fp_addsub_pkg::fp_step_e     step,
    input  wire fp_addsub_pkg::fp_aligned_t  aligned,
    input  wire fp_addsub_pkg::fp_op_e       op,
    output fp_addsub_pkg::fp_sum_t          sum
);

    import fp_addsub_pkg::*;

    // Sign bit plus carry bit above the extended mantissa
    logic [EXT_W+1:0] signed_a;
    logic [EXT_W+1:0] signed_b;
    logic [EXT_W+1:0] total;
    logic [EXT_W+1:0] neg_total;

    // Negate when the sign is set
    function automatic logic [EXT_W+1:0] to_signed(input logic s, input logic [EXT_W-1:0] m);
        logic [EXT_W+1:0] wide;
        wide = {2'b00, m};
        return s ? -wide : wide;
    endfunction

    assign neg_total = -total;

    // --------------------------------------
    // Signed forms and raw sum
    // --------------------------------------
    always_ff @(posedge clk_sys) begin
        if (step == ST_SIGNED) begin
            signed_a <= to_signed(aligned.sign_a, aligned.mant_a);
            signed_b <= to_signed(aligned.sign_b, aligned.mant_b);
        end
        if (step == ST_ADD) begin
            total <= (op == FP_OP_ADD) ? signed_a + signed_b : signed_a - signed_b;
        end
    end

    // Sign and magnitude, exponent carried along
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            sum <= '0;
        end else if (step == ST_MAGNITUDE) begin
            sum.sign      <= total[EXT_W+1];
            sum.exponent  <= {2'b00, aligned.exponent};
            sum.magnitude <= total[EXT_W+1] ? neg_total[EXT_W:0] : total[EXT_W:0];
        end
    end

endmodule

`default_nettype wire

// File: design/fp_align.sv
// FP operand unpack and exponent alignment
// Adds the hidden one and guard bits, shifts the smaller operand right

`timescale 1ns/1ps
`default_nettype none

module fp_align (
    input  wire                         clk_sys,
    input  wire                         rst_sys_n,
    input  wire fp_addsub_pkg::fp_step_e step,
    input  wire fp_addsub_pkg::fp_req_t  req,
    output fp_addsub_pkg::fp_aligned_t  aligned,
    output fp_addsub_pkg::fp_op_e       op
);

    import fp_addsub_pkg::*;

    fp_req_t          req_q;
    logic [EXP_W-1:0] exp_a;
    logic [EXP_W-1:0] exp_b;
    logic [EXP_W:0]   exp_diff;
    logic             a_smaller;
    logic [EXP_W-1:0] shift_amt;

    // Zero operand gives zero mantissa, else hidden one and guard zeros
    function automatic logic [EXT_W-1:0] unpack_mant(input logic [EXP_W+FRAC_W:0] x);
        if (x[EXP_W+FRAC_W-1:0] == '0) begin
            return '0;
        end
        return {1'b1, x[FRAC_W-1:0], {GUARD_W{1'b0}}};
    endfunction

    // Signed difference, sign bit on top
    assign exp_diff = {1'b0, exp_a} - {1'b0, exp_b};

    // Request latch open while idle, so the start edge captures it
    always_ff @(posedge clk_sys) begin
        if (step == ST_IDLE) begin
            req_q <= req;
        end
    end

    // --------------------------------------
    // Shift control and opcode
    // --------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            op        <= FP_OP_ADD;
            a_smaller <= 1'b0;
            shift_amt <= '0;
        end else begin
            if (step == ST_UNPACK) begin
                op <= req_q.op;
            end
            if (step == ST_EXPDIFF) begin
                a_smaller <= exp_diff[EXP_W];
                // Absolute value of the difference
                shift_amt <= exp_diff[EXP_W] ? -exp_diff[EXP_W-1:0] : exp_diff[EXP_W-1:0];
            end
        end
    end

    // --------------------------------------
    // Unpack, then align in place
    // --------------------------------------
    always_ff @(posedge clk_sys) begin
        case (step)
            ST_UNPACK: begin
                aligned.sign_a <= req_q.a[EXP_W+FRAC_W];
                aligned.sign_b <= req_q.b[EXP_W+FRAC_W];
                aligned.mant_a <= unpack_mant(req_q.a);
                aligned.mant_b <= unpack_mant(req_q.b);
                exp_a          <= req_q.a[FRAC_W +: EXP_W];
                exp_b          <= req_q.b[FRAC_W +: EXP_W];
            end
            ST_ALIGN: begin
                // Smaller one shifts, larger exponent kept
                if (a_smaller) begin
                    aligned.mant_a   <= aligned.mant_a >> shift_amt;
                    aligned.exponent <= exp_b;
                end else begin
                    aligned.mant_b   <= aligned.mant_b >> shift_amt;
                    aligned.exponent <= exp_a;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/fp_addsub_pkg.sv
// FP add/sub shared definitions
// Format widths, opcode and step enums, datapath structs

`default_nettype none

package fp_addsub_pkg;

    // --------------------------------------
    // Single-precision format
    // --------------------------------------
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    // Hidden one plus stored fraction
    localparam int MANT_W   = 24;
    // Guard bits below the mantissa, kept through align and add
    localparam int GUARD_W  = 24;
    localparam int EXT_W    = MANT_W + GUARD_W;
    // Last leading-one position checked, counted down from the carry bit
    localparam int NORM_MAX = 25;
    // Largest finite biased exponent
    localparam int EXP_MAX  = 254;

    // --------------------------------------
    // Opcodes and controller steps
    // --------------------------------------
    typedef enum logic {
        FP_OP_SUB = 1'b0,
        FP_OP_ADD = 1'b1
    } fp_op_e;

    typedef enum logic [3:0] {
        ST_IDLE      = 4'd0,
        ST_UNPACK    = 4'd1,
        ST_EXPDIFF   = 4'd2,
        ST_ALIGN     = 4'd3,
        ST_SIGNED    = 4'd4,
        ST_ADD       = 4'd5,
        ST_MAGNITUDE = 4'd6,
        ST_SEARCH    = 4'd7,
        ST_SHIFT     = 4'd8,
        ST_PACK      = 4'd9
    } fp_step_e;

    // --------------------------------------
    // Datapath structs
    // --------------------------------------
    // Request, two 32-bit operands
    typedef struct packed {
        fp_op_e                  op;
        logic [EXP_W+FRAC_W:0]   a;
        logic [EXP_W+FRAC_W:0]   b;
    } fp_req_t;

    typedef struct packed {
        logic                    overflow;
        logic                    zero;
        logic [EXP_W+FRAC_W:0]   result;
    } fp_rsp_t;

    // Exponent is the larger of the two after alignment
    typedef struct packed {
        logic                    sign_a;
        logic                    sign_b;
        logic [EXP_W-1:0]        exponent;
        logic [EXT_W-1:0]        mant_a;
        logic [EXT_W-1:0]        mant_b;
    } fp_aligned_t;

    // Magnitude has one carry bit above the extended mantissa
    typedef struct packed {
        logic                    sign;
        logic [EXP_W+1:0]        exponent;
        logic [EXT_W:0]          magnitude;
    } fp_sum_t;

endpackage

`default_nettype wire
